// ==== Bender.yml ====
package:
  name: core

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/memory_arbiter.sv
      - logic/fetch_unit.sv
      - logic/load_store_unit.sv
      - logic/execute_unit.sv
      - logic/core_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - test/memory_model.sv
      - test/core_tb.sv

// ==== logic/core_config.svh ====
// widths of the data path and the memory bus
// register file size
// instruction encodings used by decode and fetch
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and bus widths
`define XLEN            32
`define MEM_DATA_WIDTH  64
`define MEM_TAG_WIDTH   4

// architectural registers
`define REG_COUNT       32
`define REG_IDX_WIDTH   5

// addi x0, x0, 0 and wfi
`define INST_NOP        32'h0000_0013
`define INST_WFI        32'h1050_0073

// major opcodes and function fields of the kept instructions
`define OPCODE_OP_IMM   7'b0010011
`define OPCODE_OP       7'b0110011
`define OPCODE_LOAD     7'b0000011
`define OPCODE_STORE    7'b0100011
`define FUNCT3_ADD      3'b000
`define FUNCT3_WORD     3'b010
`define FUNCT7_ADD      7'b0000000
`define FUNCT7_SUB      7'b0100000

// first fetch address
`define RESET_PC        32'h0000_0000

`endif

// ==== logic/core_pkg.sv ====
// bus commands, access sizes, opcodes and error codes
// FSM state enums for the bus requesters and execute
// packed structs carried between the core blocks
`default_nettype none

`include "core_config.svh"

package core_pkg;

	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_e;

	typedef enum logic [1:0] {
		BYTE   = 2'h0,
		HALF   = 2'h1,
		WORD   = 2'h2,
		DOUBLE = 2'h3
	} mem_size_e;

	// decoded operation
	typedef enum logic [2:0] {
		OP_ADDI,
		OP_ADD,
		OP_SUB,
		OP_LW,
		OP_SW,
		OP_WFI,
		OP_ILLEGAL
	} opcode_e;

	typedef enum logic [1:0] {
		NO_ERROR      = 2'h0,
		HALTED_ON_WFI = 2'h1,
		ILLEGAL_INST  = 2'h2
	} error_status_e;

	// shared by fetch and load/store
	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		WAIT_REPLY
	} bus_state_e;

	typedef enum logic [1:0] {
		RUN,
		WAIT_MEM,
		HALTED
	} exec_state_e;

	// one requester's view of the bus
	typedef struct packed {
		bus_command_e        command;
		logic [`XLEN-1:0]    addr;
		logic [`XLEN-1:0]    data;
		mem_size_e           size;
	} bus_request_t;

	typedef struct packed {
		logic                valid;
		logic [31:0]         word;
		logic [`XLEN-1:0]    pc;
		logic [`XLEN-1:0]    npc;
	} fetch_packet_t;

	typedef struct packed {
		logic                      valid;
		logic                      store;
		logic [`XLEN-1:0]          addr;
		logic [`XLEN-1:0]          data;
		logic [`REG_IDX_WIDTH-1:0] dest_reg;
		logic [`XLEN-1:0]          npc;
	} mem_op_t;

	typedef struct packed {
		logic                valid;
		logic [`XLEN-1:0]    data;
	} load_result_t;

	typedef struct packed {
		logic                      valid;
		logic                      wr_en;
		logic [`REG_IDX_WIDTH-1:0] wr_idx;
		logic [`XLEN-1:0]          wr_data;
		logic [`XLEN-1:0]          npc;
		error_status_e             error;
	} commit_packet_t;

endpackage

`default_nettype wire

// ==== logic/core_top.sv ====
// top level of the core
// fetch and load/store share the memory bus through the arbiter
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module core_top import core_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic [`MEM_TAG_WIDTH-1:0]  mem2proc_response,
	input  logic [`MEM_DATA_WIDTH-1:0] mem2proc_data,
	input  logic [`MEM_TAG_WIDTH-1:0]  mem2proc_tag,
	output bus_command_e               proc2mem_command,
	output logic [`XLEN-1:0]           proc2mem_addr,
	output logic [`MEM_DATA_WIDTH-1:0] proc2mem_data,
	output mem_size_e                  proc2mem_size,
	output commit_packet_t             commit
);

	// bus requests and grants
	bus_request_t  fetch_request;
	bus_request_t  data_request;
	logic          fetch_grant;
	logic          data_grant;

	// fetch to execute
	fetch_packet_t inst;
	logic          take;

	// execute to load/store and back
	mem_op_t       mem_op;
	load_result_t  load_result;

	//////////////////////////////////////////////////////////////////////
	// bus peers
	//////////////////////////////////////////////////////////////////////

	memory_arbiter arbiter_0 (
		.clock            (clock),
		.reset            (reset),
		.fetch_request    (fetch_request),
		.data_request     (data_request),
		.fetch_grant      (fetch_grant),
		.data_grant       (data_grant),
		.proc2mem_command (proc2mem_command),
		.proc2mem_addr    (proc2mem_addr),
		.proc2mem_data    (proc2mem_data),
		.proc2mem_size    (proc2mem_size)
	);

	fetch_unit fetch_0 (
		.clock             (clock),
		.reset             (reset),
		.fetch_grant       (fetch_grant),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.take              (take),
		.fetch_request     (fetch_request),
		.inst              (inst)
	);

	load_store_unit lsu_0 (
		.clock             (clock),
		.reset             (reset),
		.mem_op            (mem_op),
		.data_grant        (data_grant),
		.mem2proc_response (mem2proc_response),
		.mem2proc_tag      (mem2proc_tag),
		.mem2proc_data     (mem2proc_data),
		.data_request      (data_request),
		.load_result       (load_result)
	);

	// decode through commit
	execute_unit execute_0 (
		.clock       (clock),
		.reset       (reset),
		.inst        (inst),
		.load_result (load_result),
		.take        (take),
		.mem_op      (mem_op),
		.commit      (commit)
	);

endmodule

`default_nettype wire

// ==== logic/execute_unit.sv ====
// decode, register file and ALU
// load/store dispatch, registered commit, halt control
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module execute_unit import core_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  fetch_packet_t  inst,
	input  load_result_t   load_result,
	output logic           take,
	output mem_op_t        mem_op,
	output commit_packet_t commit
);

	exec_state_e               state;
	opcode_e                   op;
	logic [31:0]               word;
	logic [`REG_IDX_WIDTH-1:0] rd;
	logic [`REG_IDX_WIDTH-1:0] rs1;
	logic [`REG_IDX_WIDTH-1:0] rs2;
	logic [`XLEN-1:0]          imm_i;
	logic [`XLEN-1:0]          imm_s;
	logic [`XLEN-1:0]          rs1_val;
	logic [`XLEN-1:0]          rs2_val;
	logic [`XLEN-1:0]          alu_result;
	logic [`XLEN-1:0]          regs [`REG_COUNT];
	commit_packet_t            next_commit;

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	// empty buffer decodes as a nop
	assign word  = inst.valid ? inst.word : `INST_NOP;
	assign rd    = word[11:7];
	assign rs1   = word[19:15];
	assign rs2   = word[24:20];
	assign imm_i = {{20{word[31]}}, word[31:20]};
	assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};

	always_comb begin
		op = OP_ILLEGAL;
		if (word == `INST_WFI) begin
			op = OP_WFI;
		end else if (word[6:0] == `OPCODE_OP_IMM && word[14:12] == `FUNCT3_ADD) begin
			op = OP_ADDI;
		end else if (word[6:0] == `OPCODE_OP && word[14:12] == `FUNCT3_ADD) begin
			if (word[31:25] == `FUNCT7_ADD) begin
				op = OP_ADD;
			end else if (word[31:25] == `FUNCT7_SUB) begin
				op = OP_SUB;
			end
		end else if (word[6:0] == `OPCODE_LOAD && word[14:12] == `FUNCT3_WORD) begin
			op = OP_LW;
		end else if (word[6:0] == `OPCODE_STORE && word[14:12] == `FUNCT3_WORD) begin
			op = OP_SW;
		end
	end

	// x0 always reads zero
	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

	always_comb begin
		case (op)
			OP_ADD:  alu_result = rs1_val + rs2_val;
			OP_SUB:  alu_result = rs1_val - rs2_val;
			OP_SW:   alu_result = rs1_val + imm_s;
			// addi and lw share base plus imm_i
			default: alu_result = rs1_val + imm_i;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// commit and control
	//////////////////////////////////////////////////////////////////////

	assign take = (state == RUN) && inst.valid;

	always_comb begin
		next_commit         = '0;
		next_commit.error   = commit.error;
		if (take) begin
			next_commit.npc    = inst.npc;
			next_commit.wr_idx = rd;
			next_commit.valid  = (op != OP_LW) && (op != OP_SW);
			if (op == OP_ADDI || op == OP_ADD || op == OP_SUB) begin
				next_commit.wr_en   = (rd != '0);
				next_commit.wr_data = alu_result;
			end else if (op == OP_WFI) begin
				next_commit.error = HALTED_ON_WFI;
			end else if (op == OP_ILLEGAL) begin
				next_commit.error = ILLEGAL_INST;
			end
		end else if (state == WAIT_MEM && load_result.valid) begin
			// loads write back, stores only retire
			next_commit.valid   = 1'b1;
			next_commit.npc     = mem_op.npc;
			next_commit.wr_idx  = mem_op.dest_reg;
			next_commit.wr_en   = !mem_op.store && (mem_op.dest_reg != '0);
			next_commit.wr_data = mem_op.store ? '0 : load_result.data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= RUN;
			mem_op.valid <= 1'b0;
			commit.valid <= 1'b0;
			commit.error <= NO_ERROR;
		end else begin
			commit       <= next_commit;
			mem_op.valid <= take && (op == OP_LW || op == OP_SW);
			if (take && (op == OP_LW || op == OP_SW)) begin
				state <= WAIT_MEM;
			end else if (take && (op == OP_WFI || op == OP_ILLEGAL)) begin
				state <= HALTED;
			end else if (state == WAIT_MEM && load_result.valid) begin
				state <= RUN;
			end
		end
	end

	// operation payload holds until the reply
	always_ff @(posedge clock) begin
		if (take) begin
			mem_op.store    <= (op == OP_SW);
			mem_op.addr     <= alu_result;
			mem_op.data     <= rs2_val;
			mem_op.dest_reg <= rd;
			mem_op.npc      <= inst.npc;
		end
		if (next_commit.wr_en) begin
			regs[next_commit.wr_idx] <= next_commit.wr_data;
		end
	end

	// load/store unit only answers an issued operation
	result_expected: assert property (@(posedge clock) disable iff (reset)
		load_result.valid |-> state == WAIT_MEM);

endmodule

`default_nettype wire

// ==== logic/fetch_unit.sv ====
// program counter and instruction fetch FSM
// one-entry prefetch buffer feeding execute
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module fetch_unit import core_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       fetch_grant,
	input  logic [`MEM_TAG_WIDTH-1:0]  mem2proc_response,
	input  logic [`MEM_TAG_WIDTH-1:0]  mem2proc_tag,
	input  logic [`MEM_DATA_WIDTH-1:0] mem2proc_data,
	input  logic                       take,
	output bus_request_t               fetch_request,
	output fetch_packet_t              inst
);

	bus_state_e                state;
	logic [`XLEN-1:0]          pc;
	logic [`MEM_TAG_WIDTH-1:0] tag;
	logic                      accepted;
	logic                      replied;

	// prefetch buffer
	logic                      buf_valid;
	logic [31:0]               buf_word;
	logic [`XLEN-1:0]          buf_pc;

	// response becomes our tag when memory takes the request
	assign accepted = (state == REQUEST) && fetch_grant && (mem2proc_response != '0);
	assign replied  = (state == WAIT_REPLY) && (mem2proc_tag == tag);

	// double word read at the aligned address
	always_comb begin
		fetch_request         = '0;
		fetch_request.addr    = {pc[`XLEN-1:3], 3'b000};
		fetch_request.size    = DOUBLE;
		if (state == REQUEST) begin
			fetch_request.command = BUS_LOAD;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= IDLE;
			pc        <= `RESET_PC;
			buf_valid <= 1'b0;
		end else begin
			case (state)
				// next fetch only once the buffer is free
				IDLE: begin
					if (!buf_valid || take) begin
						state <= REQUEST;
					end
				end
				// losing the grant just holds the command
				REQUEST: begin
					if (accepted) begin
						state <= WAIT_REPLY;
					end
				end
				WAIT_REPLY: begin
					if (replied) begin
						state <= IDLE;
						pc    <= pc + `XLEN'd4;
					end
				end
				default: state <= IDLE;
			endcase
			// refill wins over take in the same cycle
			if (replied) begin
				buf_valid <= 1'b1;
			end else if (take) begin
				buf_valid <= 1'b0;
			end
		end
	end

	// tag and buffer payload
	always_ff @(posedge clock) begin
		if (accepted) begin
			tag <= mem2proc_response;
		end
		if (replied) begin
			// pc bit 2 picks the upper word
			buf_word <= pc[2] ? mem2proc_data[`MEM_DATA_WIDTH-1:`XLEN]
			                  : mem2proc_data[`XLEN-1:0];
			buf_pc   <= pc;
		end
	end

	assign inst.valid = buf_valid;
	assign inst.word  = buf_word;
	assign inst.pc    = buf_pc;
	assign inst.npc   = buf_pc + `XLEN'd4;

	// every fetch starts from a word aligned pc
	fetch_aligned: assert property (@(posedge clock) disable iff (reset)
		fetch_request.command != BUS_NONE |-> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== logic/load_store_unit.sv ====
// data access FSM on the shared bus
// word loads and stores, load data returned to execute
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module load_store_unit import core_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  mem_op_t                    mem_op,
	input  logic                       data_grant,
	input  logic [`MEM_TAG_WIDTH-1:0]  mem2proc_response,
	input  logic [`MEM_TAG_WIDTH-1:0]  mem2proc_tag,
	input  logic [`MEM_DATA_WIDTH-1:0] mem2proc_data,
	output bus_request_t               data_request,
	output load_result_t               load_result
);

	bus_state_e                state;
	logic [`MEM_TAG_WIDTH-1:0] tag;
	logic                      accepted;
	logic                      replied;

	// latched operation
	logic                      op_store;
	logic [`XLEN-1:0]          op_addr;
	logic [`XLEN-1:0]          op_data;

	assign accepted = (state == REQUEST) && data_grant && (mem2proc_response != '0);
	assign replied  = (state == WAIT_REPLY) && (mem2proc_tag == tag);

	always_comb begin
		data_request      = '0;
		data_request.addr = op_addr;
		data_request.data = op_data;
		data_request.size = WORD;
		if (state == REQUEST) begin
			data_request.command = op_store ? BUS_STORE : BUS_LOAD;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state             <= IDLE;
			load_result.valid <= 1'b0;
		end else begin
			load_result.valid <= 1'b0;
			case (state)
				IDLE: begin
					if (mem_op.valid) begin
						state <= REQUEST;
					end
				end
				// a store is done once accepted
				REQUEST: begin
					if (accepted) begin
						state             <= op_store ? IDLE : WAIT_REPLY;
						load_result.valid <= op_store;
					end
				end
				WAIT_REPLY: begin
					if (replied) begin
						state             <= IDLE;
						load_result.valid <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		if (state == IDLE && mem_op.valid) begin
			op_store <= mem_op.store;
			op_addr  <= mem_op.addr;
			op_data  <= mem_op.data;
		end
		if (accepted) begin
			tag <= mem2proc_response;
		end
		if (replied) begin
			load_result.data <= mem2proc_data[`XLEN-1:0];
		end
	end

	// execute waits for each result before the next issue
	no_issue_when_busy: assert property (@(posedge clock) disable iff (reset)
		mem_op.valid |-> state == IDLE);

endmodule

`default_nettype wire

// ==== logic/memory_arbiter.sv ====
// shared memory bus arbiter
// data requests win over fetch
// memory ports driven from the winner
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module memory_arbiter import core_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  bus_request_t               fetch_request,
	input  bus_request_t               data_request,
	output logic                       fetch_grant,
	output logic                       data_grant,
	output bus_command_e               proc2mem_command,
	output logic [`XLEN-1:0]           proc2mem_addr,
	output logic [`MEM_DATA_WIDTH-1:0] proc2mem_data,
	output mem_size_e                  proc2mem_size
);

	bus_request_t winner;

	// any data command takes the bus
	assign data_grant  = (data_request.command != BUS_NONE);
	assign fetch_grant = !data_grant;

	always_comb begin
		winner = fetch_request;
		if (data_grant) begin
			winner = data_request;
		end
	end

	assign proc2mem_command = winner.command;
	assign proc2mem_addr    = winner.addr;
	// store data rides in the low word
	assign proc2mem_data    = {{(`MEM_DATA_WIDTH-`XLEN){1'b0}}, winner.data};
	assign proc2mem_size    = winner.size;

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// a fetch that loses the grant keeps its command and retries
	fetch_retry: assert property (@(posedge clock) disable iff (reset)
		fetch_request.command != BUS_NONE && !fetch_grant |=>
			fetch_request.command != BUS_NONE);

	// both requesters come out of reset quiet
	quiet_after_reset: assert property (@(posedge clock)
		reset |=> proc2mem_command == BUS_NONE);

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+logic
logic/core_pkg.sv
logic/memory_arbiter.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/execute_unit.sv
logic/core_top.sv
test/memory_model.sv
test/core_tb.sv

// ==== test/core_tb.sv ====
// testbench for core_top
// clock, reset, memory model, ISA reference model and checks
// bus rules, commit order and halt on wfi
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module core_tb import core_pkg::*;;

	logic                       clock;
	logic                       reset;
	logic [`MEM_TAG_WIDTH-1:0]  mem2proc_response;
	logic [`MEM_TAG_WIDTH-1:0]  mem2proc_tag;
	logic [`MEM_DATA_WIDTH-1:0] mem2proc_data;
	bus_command_e               proc2mem_command;
	logic [`XLEN-1:0]           proc2mem_addr;
	logic [`MEM_DATA_WIDTH-1:0] proc2mem_data;
	mem_size_e                  proc2mem_size;
	commit_packet_t             commit;

	// ISA reference model
	logic [`XLEN-1:0] model_regs [`REG_COUNT];
	logic [`XLEN-1:0] model_mem [128];
	logic [`XLEN-1:0] model_pc;
	logic [31:0]      model_word;
	logic [`XLEN-1:0] predicted_store_addr;
	logic             store_addr_ok;
	logic             halted;
	logic             was_reset;
	int               commit_count;
	int               cycles;

	localparam int PROGRAM_LENGTH = 24;
	localparam int CYCLE_LIMIT    = 2000;

	core_top uut (
		.clock             (clock),
		.reset             (reset),
		.mem2proc_response (mem2proc_response),
		.mem2proc_data     (mem2proc_data),
		.mem2proc_tag      (mem2proc_tag),
		.proc2mem_command  (proc2mem_command),
		.proc2mem_addr     (proc2mem_addr),
		.proc2mem_data     (proc2mem_data),
		.proc2mem_size     (proc2mem_size),
		.commit            (commit)
	);

	memory_model mem (
		.clock               (clock),
		.reset               (reset),
		.command             (proc2mem_command),
		.addr                (proc2mem_addr),
		.wdata               (proc2mem_data),
		.size                (proc2mem_size),
		.response            (mem2proc_response),
		.tag                 (mem2proc_tag),
		.rdata               (mem2proc_data),
		.view_addr           (model_pc),
		.view_word           (model_word),
		.expected_store_addr (predicted_store_addr),
		.store_addr_ok       (store_addr_ok)
	);

	// next store goes to base plus s-type immediate
	assign predicted_store_addr = model_regs[model_word[19:15]]
		+ {{20{model_word[31]}}, model_word[31:25], model_word[11:7]};

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// bus checks
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		if (was_reset) begin
			assert (proc2mem_command == BUS_NONE)
				else fail_run($sformatf("** Error at %0t: bus active out of reset", $time));
		end
		if (!reset && proc2mem_command != BUS_NONE) begin
			// fetches stay in the program region, data in the data region
			if (proc2mem_size == DOUBLE) begin
				assert (proc2mem_command == BUS_LOAD && proc2mem_addr[2:0] == 3'b000
						&& proc2mem_addr < 32'h100)
					else fail_run($sformatf("** Error at %0t: bad fetch at %h",
						$time, proc2mem_addr));
			end else begin
				assert (proc2mem_size == WORD && proc2mem_addr[1:0] == 2'b00
						&& proc2mem_addr >= 32'h100)
					else fail_run($sformatf("** Error at %0t: bad data access at %h",
						$time, proc2mem_addr));
			end
		end
		assert (store_addr_ok)
			else fail_run($sformatf("** Error at %0t: store address differs from model",
				$time));
		was_reset <= reset;
	end

	//////////////////////////////////////////////////////////////////////
	// commit checks against the model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin : check_commit
		logic [4:0]       rd;
		logic [`XLEN-1:0] r1;
		logic [`XLEN-1:0] r2;
		logic [`XLEN-1:0] ea;
		logic [`XLEN-1:0] exp_data;
		logic             exp_en;
		error_status_e    exp_err;
		rd       = model_word[11:7];
		r1       = model_regs[model_word[19:15]];
		r2       = model_regs[model_word[24:20]];
		exp_data = '0;
		exp_en   = 1'b0;
		exp_err  = NO_ERROR;
		if (halted) begin
			assert (commit.error == HALTED_ON_WFI)
				else fail_run($sformatf("** Error at %0t: halt status lost", $time));
		end
		if (!reset && commit.valid) begin
			assert (!halted)
				else fail_run($sformatf("** Error at %0t: commit after wfi", $time));
			if (model_word == `INST_WFI) begin
				exp_err = HALTED_ON_WFI;
			end else if (model_word[6:0] == 7'b0010011) begin
				exp_data = r1 + {{20{model_word[31]}}, model_word[31:20]};
				exp_en   = (rd != 0);
			end else if (model_word[6:0] == 7'b0110011) begin
				exp_data = model_word[30] ? r1 - r2 : r1 + r2;
				exp_en   = (rd != 0);
			end else if (model_word[6:0] == 7'b0000011) begin
				ea       = r1 + {{20{model_word[31]}}, model_word[31:20]};
				exp_data = model_mem[ea[8:2]];
				exp_en   = (rd != 0);
			end else begin
				model_mem[predicted_store_addr[8:2]] = r2;
			end
			assert (commit.npc == model_pc + 4)
				else fail_run($sformatf("** Error at %0t: npc %h, expected %h",
					$time, commit.npc, model_pc + 4));
			assert (commit.wr_en == exp_en && commit.error == exp_err)
				else fail_run($sformatf("** Error at %0t: wr_en/error wrong at pc %h",
					$time, model_pc));
			if (exp_en) begin
				assert (commit.wr_idx == rd && commit.wr_data == exp_data)
					else fail_run($sformatf("** Error at %0t: x%0d = %h, expected x%0d = %h",
						$time, commit.wr_idx, commit.wr_data, rd, exp_data));
				model_regs[rd] = exp_data;
			end
			halted       = (exp_err == HALTED_ON_WFI);
			model_pc     = model_pc + 4;
			commit_count = commit_count + 1;
		end
	end

	// timeout from the program length and worst case per instruction
	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			fail_run("timeout: the core did not halt within the cycle limit");
		end
	end

	initial begin
		reset        = 1'b1;
		model_pc     = `RESET_PC;
		halted       = 1'b0;
		was_reset    = 1'b0;
		commit_count = 0;
		cycles       = 0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		for (int i = 0; i < 128; i++) begin
			model_mem[i] = {16'hc3a5 ^ 16'(i * 4), 16'(i * 4)};
		end
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		wait (halted);
		// quiet period after wfi
		repeat (50) @(posedge clock);
		if (commit_count == PROGRAM_LENGTH && commit.error == HALTED_ON_WFI) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			fail_run($sformatf("** Error at %0t: %0d commits, expected %0d",
				$time, commit_count, PROGRAM_LENGTH));
		end
	end

endmodule

`default_nettype wire

// ==== test/memory_model.sv ====
// behavioral memory on the shared bus
// tagged accept-then-reply with random refusal and reply delay
// preloaded test program and patterned data region
`timescale 1ns/1ns
`default_nettype none

`include "core_config.svh"

module memory_model import core_pkg::*; (
	input  logic                       clock,
	input  logic                       reset,
	input  bus_command_e               command,
	input  logic [`XLEN-1:0]           addr,
	input  logic [`MEM_DATA_WIDTH-1:0] wdata,
	input  mem_size_e                  size,
	output logic [`MEM_TAG_WIDTH-1:0]  response,
	output logic [`MEM_TAG_WIDTH-1:0]  tag,
	output logic [`MEM_DATA_WIDTH-1:0] rdata,
	input  logic [`XLEN-1:0]           view_addr,
	output logic [31:0]                view_word,
	input  logic [`XLEN-1:0]           expected_store_addr,
	output logic                       store_addr_ok
);

	// 512 bytes as words, program from 0, data from 0x100
	logic [31:0]               words [128];
	logic [`MEM_TAG_WIDTH-1:0] next_tag;
	logic                      refuse;
	integer                    seed;

	// replies waiting for their delay
	logic [`MEM_TAG_WIDTH-1:0]  pend_tag [$];
	logic [`MEM_DATA_WIDTH-1:0] pend_data [$];
	int                         pend_wait [$];

	function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
		enc_addi = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_rtype(input bit sub, input int rd, input int rs1,
			input int rs2);
		enc_rtype = {1'b0, sub, 5'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_lw(input int rd, input int rs1, input int imm);
		enc_lw = {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic logic [31:0] enc_sw(input int rs2, input int rs1, input int imm);
		enc_sw = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	initial begin
		seed     = 32'h7398e6d9;
		next_tag = 1;
		refuse   = 1'b0;
		tag      = '0;
		rdata    = '0;
		store_addr_ok = 1'b1;
		// fill pattern from the full byte address
		for (int i = 0; i < 128; i++) begin
			words[i] = {16'hc3a5 ^ 16'(i * 4), 16'(i * 4)};
		end
		words[0]  = enc_addi(1, 0, 256);
		words[1]  = enc_addi(2, 0, 100);
		words[2]  = enc_addi(3, 0, -7);
		words[3]  = enc_rtype(0, 4, 2, 3);
		words[4]  = enc_rtype(1, 5, 2, 3);
		words[5]  = enc_sw(4, 1, 0);
		words[6]  = enc_lw(6, 1, 0);
		words[7]  = enc_lw(7, 1, 4);
		words[8]  = enc_lw(8, 1, 12);
		words[9]  = enc_rtype(0, 9, 7, 8);
		words[10] = enc_sw(9, 1, 8);
		words[11] = enc_sw(5, 1, 20);
		// write to x0, then read it back
		words[12] = enc_addi(0, 2, 55);
		words[13] = enc_rtype(0, 10, 0, 2);
		words[14] = enc_lw(11, 1, 8);
		words[15] = enc_rtype(1, 12, 11, 6);
		words[16] = enc_sw(12, 1, 16);
		words[17] = enc_lw(13, 1, 16);
		words[18] = enc_lw(14, 1, 20);
		words[19] = enc_addi(15, 13, 2047);
		words[20] = enc_rtype(1, 16, 15, 14);
		words[21] = enc_lw(17, 1, 28);
		words[22] = enc_rtype(0, 18, 17, 16);
		words[23] = `INST_WFI;
	end

	assign view_word = words[view_addr[8:2]];

	// accept whenever not refusing, the response is the tag
	assign response = (!reset && command != BUS_NONE && !refuse) ? next_tag : '0;

	always @(posedge clock) begin : bus_side
		int delay;
		if (reset) begin
			next_tag <= 1;
			refuse   <= 1'b0;
			tag      <= '0;
			pend_tag.delete();
			pend_data.delete();
			pend_wait.delete();
		end else begin
			refuse <= ($random(seed) & 3) == 0;
			tag    <= '0;
			// oldest reply goes out once its delay is over
			if (pend_wait.size() > 0 && pend_wait[0] == 0) begin
				tag   <= pend_tag.pop_front();
				rdata <= pend_data.pop_front();
				void'(pend_wait.pop_front());
			end
			foreach (pend_wait[i]) begin
				if (pend_wait[i] > 0) begin
					pend_wait[i] = pend_wait[i] - 1;
				end
			end
			if (response != '0) begin
				next_tag <= (next_tag == 15) ? 1 : next_tag + 1;
				if (command == BUS_STORE) begin
					words[addr[8:2]] <= wdata[31:0];
					if (addr != expected_store_addr) begin
						store_addr_ok <= 1'b0;
					end
				end else begin
					delay = $unsigned($random(seed)) % 6;
					pend_tag.push_back(response);
					pend_wait.push_back(delay);
					// word reads come back in the low half
					if (size == DOUBLE) begin
						pend_data.push_back({words[{addr[8:3], 1'b1}], words[{addr[8:3], 1'b0}]});
					end else begin
						pend_data.push_back({32'h0, words[addr[8:2]]});
					end
				end
			end
		end
	end

endmodule

`default_nettype wire
